//--- verilog/accum_pkg.sv
// shared sizes, tile position struct and table address union
// result row and readout row types for the accumulator subsystem
package accum_pkg;

    // systolic array geometry
    localparam int sys_arr_rows = 4;   // rows of processing elements
    localparam int sys_arr_cols = 4;   // columns, one table bank each

    // largest output matrix
    localparam int max_out_rows = 16;
    localparam int max_out_cols = 16;

    // tiles along each output dimension
    localparam int num_submats_m = max_out_rows / sys_arr_rows;
    localparam int num_submats_n = max_out_cols / sys_arr_cols;

    // table depth, one row per output row per column tile
    localparam int num_accum_rows = max_out_rows * num_submats_n;
    localparam int addr_width     = $clog2(num_accum_rows);

    localparam int data_width = 16;   // signed partial sum from the array
    localparam int acc_width  = 24;   // signed accumulator word

    // field widths of the tile position
    localparam int sub_row_width  = $clog2(sys_arr_rows);
    localparam int submat_m_width = $clog2(num_submats_m);
    localparam int submat_n_width = $clog2(num_submats_n);

    // where a result row belongs in the output matrix
    typedef struct packed {
        logic [submat_n_width-1:0] submat_n;   // tile column
        logic [submat_m_width-1:0] submat_m;   // tile row
        logic [sub_row_width-1:0]  sub_row;    // row inside the tile
    } tile_pos_t;

    // same word seen as tile fields or as a flat table index
    // n*max_out_rows + m*sys_arr_rows + sub_row is just the concatenation
    typedef union packed {
        tile_pos_t             pos;
        logic [addr_width-1:0] flat;
    } accum_addr_u;

    // per-column vectors, column 0 in the low bits
    typedef logic [sys_arr_cols-1:0][data_width-1:0] col_data_t;
    typedef accum_addr_u [sys_arr_cols-1:0]          col_addr_t;

    // one row leaving the array
    typedef struct packed {
        tile_pos_t pos;     // target position
        logic      clear;   // overwrite instead of add
        col_data_t data;    // one partial sum per column
    } result_row_t;

    // one table row as returned to the host
    typedef logic [sys_arr_cols-1:0][acc_width-1:0] table_row_t;

endpackage

//--- verilog/row_intake.sv
`timescale 1ns/1ps
// four-phase receiver for result rows with one write pulse per row
// and the per-column skew lines for data and clear
module row_intake import accum_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    row_req,
    input  result_row_t             row_in,
    output logic                    row_ack,
    input  logic                    rd_hold,
    output logic                    wr_pulse,
    output tile_pos_t               pos,
    output col_data_t               col_data,
    output logic [sys_arr_cols-1:0] col_clear
);

    logic        accept;   // row taken at the next edge
    result_row_t row_q;    // accepted row

    // new row only while ack is low and no read capture is waiting
    assign accept = row_req && !row_ack && !rd_hold;

    // handshake state
    always_ff @(posedge clk) begin
        if (reset) begin
            row_ack  <= 1'b0;
            wr_pulse <= 1'b0;
        end else begin
            wr_pulse <= accept;   // high in the cycle ack rises
            if (accept) begin
                row_ack <= 1'b1;
            end else if (row_ack && !row_req) begin
                row_ack <= 1'b0;   // requester let go
            end
        end
    end

    // row payload, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            row_q <= row_in;
        end
    end

    assign pos          = row_q.pos;
    assign col_data[0]  = row_q.data[0];   // column 0 goes straight out
    assign col_clear[0] = row_q.clear;

    // column c trails column 0 by c cycles like the array output
    for (genvar c = 1; c < sys_arr_cols; c++) begin : g_skew
        logic [c-1:0][data_width-1:0] data_line;    // c stages
        logic [c-1:0]                 clear_line;   // clear follows its data

        always_ff @(posedge clk) begin
            data_line[0]  <= row_q.data[c];
            clear_line[0] <= row_q.clear;
            for (int k = 1; k < c; k++) begin
                data_line[k]  <= data_line[k-1];    // shifts every cycle
                clear_line[k] <= clear_line[k-1];
            end
        end

        // several rows may be in flight here at once
        assign col_data[c]  = data_line[c-1];
        assign col_clear[c] = clear_line[c-1];
    end

endmodule

//--- verilog/accum_wr_control.sv
`timescale 1ns/1ps
// write address and enable pipeline for the accumulator banks
module accum_wr_control import accum_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_pulse,
    input  tile_pos_t               pos,
    output logic [sys_arr_cols-1:0] wr_en_out,
    output col_addr_t               wr_addr_out,
    output logic                    wr_busy
);

    accum_addr_u                    addr_0;   // column 0 address
    logic        [sys_arr_cols-1:1] en_q;     // delayed enables
    accum_addr_u [sys_arr_cols-1:1] addr_q;   // delayed addresses

    // column 0 address from the tile fields via the union
    always_comb begin
        addr_0.pos = pos;
    end

    // column 0 live, higher columns from their left neighbour
    assign wr_en_out   = {en_q, wr_pulse};
    assign wr_addr_out = {addr_q, addr_0};

    // enable shift register
    always_ff @(posedge clk) begin
        if (reset) begin
            en_q <= '0;
        end else begin
            en_q <= wr_en_out[sys_arr_cols-2:0];   // one column per cycle
        end
    end

    // address shift register
    always_ff @(posedge clk) begin
        addr_q <= wr_addr_out[sys_arr_cols-2:0];
    end

    // any column write still heading for the table
    // wr_pulse is bit 0 of the enable vector
    assign wr_busy = |wr_en_out;

endmodule

//--- verilog/accum_table.sv
`timescale 1ns/1ps
// accumulator banks, one per array column, with read-modify-write
// and a shared combinational read port
module accum_table import accum_pkg::*; (
    input  logic                    clk,
    input  logic [sys_arr_cols-1:0] wr_en,
    input  col_addr_t               wr_addr,
    input  col_data_t               col_data,
    input  logic [sys_arr_cols-1:0] col_clear,
    input  logic [addr_width-1:0]   rd_addr,
    output table_row_t              rd_row
);

    localparam int ext_width = acc_width - data_width;   // sign bits to add

    for (genvar c = 0; c < sys_arr_cols; c++) begin : g_bank
        logic [acc_width-1:0] bank [num_accum_rows];   // this column's words
        logic [addr_width-1:0] wr_index;   // flat view of the union
        logic [acc_width-1:0]  wr_ext;     // incoming sum, widened
        logic [acc_width-1:0]  wr_old;     // stored word at wr_index
        logic [acc_width-1:0]  wr_new;

        assign wr_index = wr_addr[c].flat;

        // sign extend the partial sum
        assign wr_ext = {{ext_width{col_data[c][data_width-1]}}, col_data[c]};

        assign wr_old = bank[wr_index];

        // clear starts a fresh sum otherwise accumulate
        assign wr_new = col_clear[c] ? wr_ext : wr_old + wr_ext;

        // each bank writes in its own cycle
        always_ff @(posedge clk) begin
            if (wr_en[c]) begin
                bank[wr_index] <= wr_new;
            end
        end

        // all banks read at the host address
        assign rd_row[c] = bank[rd_addr];
    end

endmodule

//--- verilog/drain_reader.sv
`timescale 1ns/1ps
// four-phase read server that captures one table row
// once the write pipeline has drained
module drain_reader import accum_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_req,
    input  logic [addr_width-1:0] rd_addr_in,
    output logic                  rd_ack,
    output table_row_t            rd_data,
    output logic                  rd_hold,
    input  logic                  wr_busy,
    input  logic                  row_ack,
    output logic [addr_width-1:0] rd_addr,
    input  table_row_t            rd_row
);

    logic capture;   // row sampled at the next edge

    // host address goes straight to the table port
    assign rd_addr = rd_addr_in;

    // read pending, keeps the intake from taking a new row
    assign rd_hold = rd_req && !rd_ack;

    // no column write left and no row handshake open
    // with rd_hold up the intake cannot start one either
    assign capture = rd_hold && !wr_busy && !row_ack;

    // handshake state
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ack <= 1'b0;
        end else if (capture) begin
            rd_ack <= 1'b1;   // raised with the data
        end else if (rd_ack && !rd_req) begin
            rd_ack <= 1'b0;   // host released the request
        end
    end

    // readout stays put until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            rd_data <= rd_row;
        end
    end

endmodule

//--- verilog/accum_top.sv
`timescale 1ns/1ps
// accumulator subsystem top with intake, write control, table and reader
module accum_top import accum_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  row_req,
    input  result_row_t           row_in,
    output logic                  row_ack,
    input  logic                  rd_req,
    input  logic [addr_width-1:0] rd_addr_in,
    output logic                  rd_ack,
    output table_row_t            rd_data
);

    logic                    wr_pulse;    // one per accepted row
    tile_pos_t               pos;         // position of that row
    col_data_t               col_data;    // skewed partial sums
    logic [sys_arr_cols-1:0] col_clear;   // skewed clear flags
    logic [sys_arr_cols-1:0] wr_en;       // per-bank write enable
    col_addr_t               wr_addr;     // per-bank write address
    logic                    wr_busy;     // writes still in flight
    logic                    rd_hold;     // read capture pending
    logic [addr_width-1:0]   rd_addr;     // table read address
    table_row_t              rd_row;      // table read data

    row_intake i_row_intake (
        .clk       (clk),
        .reset     (reset),
        .row_req   (row_req),
        .row_in    (row_in),
        .row_ack   (row_ack),
        .rd_hold   (rd_hold),
        .wr_pulse  (wr_pulse),
        .pos       (pos),
        .col_data  (col_data),
        .col_clear (col_clear)
    );

    accum_wr_control i_accum_wr_control (
        .clk         (clk),
        .reset       (reset),
        .wr_pulse    (wr_pulse),
        .pos         (pos),
        .wr_en_out   (wr_en),
        .wr_addr_out (wr_addr),
        .wr_busy     (wr_busy)
    );

    accum_table i_accum_table (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .col_data  (col_data),
        .col_clear (col_clear),
        .rd_addr   (rd_addr),
        .rd_row    (rd_row)
    );

    drain_reader i_drain_reader (
        .clk        (clk),
        .reset      (reset),
        .rd_req     (rd_req),
        .rd_addr_in (rd_addr_in),
        .rd_ack     (rd_ack),
        .rd_data    (rd_data),
        .rd_hold    (rd_hold),
        .wr_busy    (wr_busy),
        .row_ack    (row_ack),
        .rd_addr    (rd_addr),
        .rd_row     (rd_row)
    );

endmodule

//--- tb/tb_accum_top.sv
`timescale 1ns/1ps
// accumulator subsystem testbench driven by commands and expected rows from a data file
// drives both four-phase handshakes and keeps a small table model of the writes
module tb_accum_top import accum_pkg::*; ();

    localparam int max_cmds = 64;   // command slots

    logic        clk;
    logic        reset;
    logic        row_req;
    result_row_t row_in;
    logic        row_ack;
    logic        rd_req;
    logic [addr_width-1:0] rd_addr_in;
    logic        rd_ack;
    table_row_t  rd_data;

    // command list filled from the data file
    logic [7:0]            cmd_kind  [max_cmds];   // W or R
    tile_pos_t             cmd_pos   [max_cmds];
    logic                  cmd_clear [max_cmds];
    col_data_t             cmd_data  [max_cmds];
    logic [addr_width-1:0] cmd_addr  [max_cmds];
    table_row_t            cmd_exp   [max_cmds];
    int                    cmd_count;
    bit                    load_done;

    // reference table built from the write history
    logic [acc_width-1:0] model_row   [num_accum_rows][sys_arr_cols];
    bit                   model_valid [num_accum_rows];   // set by a clear write

    accum_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .row_req    (row_req),
        .row_in     (row_in),
        .row_ack    (row_ack),
        .rd_req     (rd_req),
        .rd_addr_in (rd_addr_in),
        .rd_ack     (rd_ack),
        .rd_data    (rd_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    // rising edge plus the drive and sample delay
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // mismatch line with time, signal and both values
    task automatic show_mismatch(string sig, logic [31:0] exp, logic [31:0] act);
        $display("error: time %0t signal %s expected %0h actual %0h", $time, sig, exp, act);
        $display("STATUS: FAIL");
    endtask

    task automatic load_commands();
        int                    fd;
        int                    code;
        bit                    done;
        logic [63:0]           tag;
        logic [8*256-1:0]      rest;
        logic [1:0]            n, m, r;
        logic                  clr;
        logic [data_width-1:0] d0, d1, d2, d3;
        logic [addr_width-1:0] a;
        logic [acc_width-1:0]  e0, e1, e2, e3;
        fd = $fopen("tb/accum_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the command file tb/accum_testdata.txt");
            $display("STATUS: FAIL");
            $fatal(1, "no stimulus");
        end
        cmd_count = 0;
        done = 0;
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1;   // end of file
            end else if (tag == "#") begin
                code = $fgets(rest, fd);   // skip comment text
            end else if ((tag == "W" || tag == "R") && cmd_count < max_cmds) begin
                if (tag == "W") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h", n, m, r, clr, d0, d1, d2, d3);
                    if (code != 8) begin
                        $display("command file has a W line with missing fields");
                        $display("STATUS: FAIL");
                        $fatal(1, "bad command file");
                    end
                    cmd_pos[cmd_count]   = '{submat_n: n, submat_m: m, sub_row: r};
                    cmd_clear[cmd_count] = clr;
                    cmd_data[cmd_count]  = {d3, d2, d1, d0};   // column 0 low
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h", a, e0, e1, e2, e3);
                    if (code != 5) begin
                        $display("command file has an R line with missing fields");
                        $display("STATUS: FAIL");
                        $fatal(1, "bad command file");
                    end
                    cmd_addr[cmd_count] = a;
                    cmd_exp[cmd_count]  = {e3, e2, e1, e0};
                end
                cmd_kind[cmd_count] = tag[7:0];
                cmd_count++;
            end else begin
                $display("command file has an unknown tag or too many commands");
                $display("STATUS: FAIL");
                $fatal(1, "bad command file");
            end
        end
        $fclose(fd);
    endtask

    // flat address is n*max_out_rows + m*sys_arr_rows + sub_row
    task automatic apply_to_model(int i);
        int                   a;
        logic [acc_width-1:0] ext;
        a = int'(cmd_pos[i].submat_n) * max_out_rows
            + int'(cmd_pos[i].submat_m) * sys_arr_rows
            + int'(cmd_pos[i].sub_row);
        for (int c = 0; c < sys_arr_cols; c++) begin
            ext = {{(acc_width-data_width){cmd_data[i][c][data_width-1]}}, cmd_data[i][c]};
            if (cmd_clear[i]) begin
                model_row[a][c] = ext;   // fresh sum
            end else begin
                model_row[a][c] = model_row[a][c] + ext;
            end
        end
        if (cmd_clear[i]) begin
            model_valid[a] = 1'b1;
        end
    endtask

    task automatic write_row(int i);
        row_in.pos   = cmd_pos[i];
        row_in.clear = cmd_clear[i];
        row_in.data  = cmd_data[i];
        row_req      = 1'b1;
        step();
        while (row_ack !== 1'b1) step();   // wait for ack
        row_req = 1'b0;
        apply_to_model(i);
        step();
        while (row_ack !== 1'b0) step();   // ack released
    endtask

    task automatic read_row(int i);
        int a;
        a = int'(cmd_addr[i]);
        rd_addr_in = cmd_addr[i];
        rd_req     = 1'b1;
        step();
        while (rd_ack !== 1'b1) step();   // capture may wait for writes
        assert (model_valid[a]) else begin
            $display("read of table row %0d which no clear write has set up", a);
            $display("STATUS: FAIL");
            $fatal(1, "read of undefined row");
        end
        for (int c = 0; c < sys_arr_cols; c++) begin
            // data file against the write history
            assert (cmd_exp[i][c] === model_row[a][c]) else begin
                show_mismatch($sformatf("testdata row %0d column %0d", a, c),
                              32'(model_row[a][c]), 32'(cmd_exp[i][c]));
                $fatal(1, "data file disagrees with the write history");
            end
            assert (rd_data[c] === cmd_exp[i][c]) else begin
                show_mismatch($sformatf("rd_data[%0d] at row %0d", c, a),
                              32'(cmd_exp[i][c]), 32'(rd_data[c]));
                $fatal(1, "readout mismatch");
            end
        end
        rd_req = 1'b0;
        step();
        while (rd_ack !== 1'b0) step();
    endtask

    // both acks must stay low in and right after reset
    task automatic check_acks_low();
        assert (row_ack === 1'b0) else begin
            show_mismatch("row_ack", 32'd0, 32'(row_ack));
            $fatal(1, "row_ack high around reset");
        end
        assert (rd_ack === 1'b0) else begin
            show_mismatch("rd_ack", 32'd0, 32'(rd_ack));
            $fatal(1, "rd_ack high around reset");
        end
    endtask

    initial begin
        reset      = 1'b1;
        row_req    = 1'b0;
        row_in     = '0;
        rd_req     = 1'b0;
        rd_addr_in = '0;
        load_done  = 1'b0;
        load_commands();
        load_done = 1'b1;
        repeat (2) begin
            step();
            check_acks_low();
        end
        reset = 1'b0;
        step();
        check_acks_low();   // first cycle out of reset
        for (int i = 0; i < cmd_count; i++) begin
            if (cmd_kind[i] == "W") begin
                write_row(i);   // next row starts as soon as ack falls
            end else begin
                read_row(i);
            end
        end
        step();
        $display("STATUS: PASS");
        $finish;
    end

    // limit scales with the command count
    initial begin
        wait (load_done);
        repeat (cmd_count * 40 + 100) @(posedge clk);
        $display("timeout: the command list did not complete within %0d cycles",
                 cmd_count * 40 + 100);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- tb/accum_testdata.txt
# W n m r clear d0 d1 d2 d3 : tile position, clear flag, 16-bit sums in hex, column 0 first
# R addr e0 e1 e2 e3 : flat table address, expected 24-bit accumulator words in hex
# clear write then read back, sign extension
W 0 0 0 1 0005 fffd 7fff 8000
R 00 000005 fffffd 007fff ff8000
# accumulate at n=1 m=2 r=3 with negative data
W 1 2 3 1 0010 0020 fff0 0001
W 1 2 3 0 0003 fffe 0010 ffff
W 1 2 3 0 fff6 0001 0005 0002
R 1b 000009 00001f 000005 000002
# distinct positions
W 3 3 3 1 1111 2222 3333 4444
W 2 0 1 1 0100 0200 0300 0400
W 0 3 0 1 00aa 00bb 00cc 00dd
W 0 0 1 1 0001 0002 0003 0004
R 3f 001111 002222 003333 004444
R 21 000100 000200 000300 000400
R 0c 0000aa 0000bb 0000cc 0000dd
R 01 000001 000002 000003 000004
R 00 000005 fffffd 007fff ff8000
R 1b 000009 00001f 000005 000002
# read right after a write ack
W 0 0 0 0 0001 0001 0001 0001
R 00 000006 fffffe 008000 ff8001
# back to back writes with overlapping skew
W 2 1 2 1 8000 8000 8000 8000
W 2 1 2 0 8000 8000 8000 8000
W 2 1 2 0 7fff 0001 ffff 0000
W 2 1 3 1 0007 0008 0009 000a
W 2 1 2 0 0001 0001 0001 0001
R 26 ff8000 ff0002 ff0000 ff0001
R 27 000007 000008 000009 00000a
# a new clear restarts the sum
W 1 2 3 1 0002 0002 0002 0002
R 1b 000002 000002 000002 000002
R 3f 001111 002222 003333 004444

//--- files.f
verilog/accum_pkg.sv
verilog/row_intake.sv
verilog/accum_wr_control.sv
verilog/accum_table.sv
verilog/drain_reader.sv
verilog/accum_top.sv
tb/tb_accum_top.sv

//--- run_sim.sh
#!/bin/sh
# compile the accumulator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_accum_top -o sim_accum

./obj_dir/sim_accum 2>&1 | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
